// ==== include/ring_cfg.svh ====
`ifndef RING_CFG_SVH
`define RING_CFG_SVH

// operand value width.
`define RING_XLEN 32

// physical register file size, sets the tag width.
`define RING_PHYS_REGS 256

// reorder buffer depth.
`define RING_ROB_SIZE 256

// number of distinct micro-op codes.
`define RING_UOP_CODES 16

`endif

// ==== logic/ring_pkg.sv ====
`include "ring_cfg.svh"

package ring_pkg;

    // unit selector carried with each micro-op, 6 and 7 are never matched.
    typedef enum logic [2:0] {
        fu_none       = 3'd0,
        fu_logical    = 3'd1,
        fu_arithmetic = 3'd2,
        fu_branch     = 3'd3,
        fu_mul_div    = 3'd4,
        fu_ld_st      = 3'd5
    } fu_code_e;

    typedef logic [`RING_XLEN-1:0]                xlen_t;
    typedef logic [$clog2(`RING_PHYS_REGS)-1:0]   preg_t;
    typedef logic [$clog2(`RING_ROB_SIZE)-1:0]    rob_idx_t;
    typedef logic [$clog2(`RING_UOP_CODES)-1:0]   uop_code_t;

endpackage

// ==== logic/uop_if.sv ====
`timescale 1ns/1ps

// one ring slot, contents are live whenever unit is not fu_none.
interface uop_if
    import ring_pkg::*;
();

    fu_code_e  unit;
    rob_idx_t  rob_entry;
    preg_t     rs1_reg;
    logic      rs1_ready;
    xlen_t     rs1_value;
    preg_t     rs2_reg;
    logic      rs2_ready;
    xlen_t     rs2_value;
    preg_t     dest_reg;
    uop_code_t uop_code;

    modport ring (
        output unit, rob_entry,
        output rs1_reg, rs1_ready, rs1_value,
        output rs2_reg, rs2_ready, rs2_value,
        output dest_reg, uop_code
    );

    modport port (
        input unit, rob_entry,
        input rs1_reg, rs1_ready, rs1_value,
        input rs2_reg, rs2_ready, rs2_value,
        input dest_reg, uop_code
    );

endinterface

// ==== logic/ring_shift.sv ====
`timescale 1ns/1ps

module ring_shift
    import ring_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      valid_in,
    input  fu_code_e  unit_in,
    input  rob_idx_t  rob_entry_in,
    input  preg_t     rs1_reg_in,
    input  logic      rs1_ready_in,
    input  xlen_t     rs1_value_in,
    input  preg_t     rs2_reg_in,
    input  logic      rs2_ready_in,
    input  xlen_t     rs2_value_in,
    input  preg_t     dest_reg_in,
    input  uop_code_t uop_code_in,
    uop_if.ring       arith_slot,
    uop_if.ring       logic_slot,
    uop_if.ring       branch_slot,
    uop_if.ring       mul_div_slot,
    uop_if.ring       ld_st_slot
);

    localparam int ring_depth = 6; // head plus five unit slots.

    fu_code_e  unit_q      [ring_depth];
    rob_idx_t  rob_entry_q [ring_depth];
    preg_t     rs1_reg_q   [ring_depth];
    logic      rs1_ready_q [ring_depth];
    xlen_t     rs1_value_q [ring_depth];
    preg_t     rs2_reg_q   [ring_depth];
    logic      rs2_ready_q [ring_depth];
    xlen_t     rs2_value_q [ring_depth];
    preg_t     dest_reg_q  [ring_depth];
    uop_code_t uop_code_q  [ring_depth];

    // unit codes mark occupancy, so only they are cleared.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ring_depth; i++) begin
                unit_q[i] <= fu_none;
            end
        end else begin
            unit_q[0] <= valid_in ? unit_in : fu_none; // idle head carries a bubble.
            for (int i = 1; i < ring_depth; i++) begin
                unit_q[i] <= unit_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            rob_entry_q[0] <= rob_entry_in;
            rs1_reg_q[0]   <= rs1_reg_in;
            rs1_ready_q[0] <= rs1_ready_in;
            rs1_value_q[0] <= rs1_value_in;
            rs2_reg_q[0]   <= rs2_reg_in;
            rs2_ready_q[0] <= rs2_ready_in;
            rs2_value_q[0] <= rs2_value_in;
            dest_reg_q[0]  <= dest_reg_in;
            uop_code_q[0]  <= uop_code_in;
        end
        for (int i = 1; i < ring_depth; i++) begin
            rob_entry_q[i] <= rob_entry_q[i-1];
            rs1_reg_q[i]   <= rs1_reg_q[i-1];
            rs1_ready_q[i] <= rs1_ready_q[i-1];
            rs1_value_q[i] <= rs1_value_q[i-1];
            rs2_reg_q[i]   <= rs2_reg_q[i-1];
            rs2_ready_q[i] <= rs2_ready_q[i-1];
            rs2_value_q[i] <= rs2_value_q[i-1];
            dest_reg_q[i]  <= dest_reg_q[i-1];
            uop_code_q[i]  <= uop_code_q[i-1];
        end
    end

    // slot order is arithmetic, logical, branch, mul/div, load/store.
    assign arith_slot.unit        = unit_q[1];
    assign arith_slot.rob_entry   = rob_entry_q[1];
    assign arith_slot.rs1_reg     = rs1_reg_q[1];
    assign arith_slot.rs1_ready   = rs1_ready_q[1];
    assign arith_slot.rs1_value   = rs1_value_q[1];
    assign arith_slot.rs2_reg     = rs2_reg_q[1];
    assign arith_slot.rs2_ready   = rs2_ready_q[1];
    assign arith_slot.rs2_value   = rs2_value_q[1];
    assign arith_slot.dest_reg    = dest_reg_q[1];
    assign arith_slot.uop_code    = uop_code_q[1];

    assign logic_slot.unit        = unit_q[2];
    assign logic_slot.rob_entry   = rob_entry_q[2];
    assign logic_slot.rs1_reg     = rs1_reg_q[2];
    assign logic_slot.rs1_ready   = rs1_ready_q[2];
    assign logic_slot.rs1_value   = rs1_value_q[2];
    assign logic_slot.rs2_reg     = rs2_reg_q[2];
    assign logic_slot.rs2_ready   = rs2_ready_q[2];
    assign logic_slot.rs2_value   = rs2_value_q[2];
    assign logic_slot.dest_reg    = dest_reg_q[2];
    assign logic_slot.uop_code    = uop_code_q[2];

    assign branch_slot.unit       = unit_q[3];
    assign branch_slot.rob_entry  = rob_entry_q[3];
    assign branch_slot.rs1_reg    = rs1_reg_q[3];
    assign branch_slot.rs1_ready  = rs1_ready_q[3];
    assign branch_slot.rs1_value  = rs1_value_q[3];
    assign branch_slot.rs2_reg    = rs2_reg_q[3];
    assign branch_slot.rs2_ready  = rs2_ready_q[3];
    assign branch_slot.rs2_value  = rs2_value_q[3];
    assign branch_slot.dest_reg   = dest_reg_q[3];
    assign branch_slot.uop_code   = uop_code_q[3];

    assign mul_div_slot.unit      = unit_q[4];
    assign mul_div_slot.rob_entry = rob_entry_q[4];
    assign mul_div_slot.rs1_reg   = rs1_reg_q[4];
    assign mul_div_slot.rs1_ready = rs1_ready_q[4];
    assign mul_div_slot.rs1_value = rs1_value_q[4];
    assign mul_div_slot.rs2_reg   = rs2_reg_q[4];
    assign mul_div_slot.rs2_ready = rs2_ready_q[4];
    assign mul_div_slot.rs2_value = rs2_value_q[4];
    assign mul_div_slot.dest_reg  = dest_reg_q[4];
    assign mul_div_slot.uop_code  = uop_code_q[4];

    assign ld_st_slot.unit        = unit_q[5]; // last slot, item drops off after this.
    assign ld_st_slot.rob_entry   = rob_entry_q[5];
    assign ld_st_slot.rs1_reg     = rs1_reg_q[5];
    assign ld_st_slot.rs1_ready   = rs1_ready_q[5];
    assign ld_st_slot.rs1_value   = rs1_value_q[5];
    assign ld_st_slot.rs2_reg     = rs2_reg_q[5];
    assign ld_st_slot.rs2_ready   = rs2_ready_q[5];
    assign ld_st_slot.rs2_value   = rs2_value_q[5];
    assign ld_st_slot.dest_reg    = dest_reg_q[5];
    assign ld_st_slot.uop_code    = uop_code_q[5];

endmodule

// ==== logic/issue_port.sv ====
`timescale 1ns/1ps

module issue_port
    import ring_pkg::*;
#(
    parameter fu_code_e port_unit = fu_arithmetic
) (
    input  logic      clk,
    input  logic      reset,
    uop_if.port       slot,
    output rob_idx_t  rob_entry,
    output preg_t     rs1_reg,
    output logic      rs1_ready,
    output xlen_t     rs1_value,
    output preg_t     rs2_reg,
    output logic      rs2_ready,
    output xlen_t     rs2_value,
    output preg_t     dest_reg,
    output uop_code_t uop_code,
    output logic      valid
);

    logic hit;

    assign hit = (slot.unit == port_unit);

    // one-cycle strobe per matching slot.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= hit;
        end
    end

    // payload holds between issues.
    always_ff @(posedge clk) begin
        if (hit) begin
            rob_entry <= slot.rob_entry;
            rs1_reg   <= slot.rs1_reg;
            rs1_ready <= slot.rs1_ready;
            rs1_value <= slot.rs1_value;
            rs2_reg   <= slot.rs2_reg;
            rs2_ready <= slot.rs2_ready;
            rs2_value <= slot.rs2_value;
            dest_reg  <= slot.dest_reg;
            uop_code  <= slot.uop_code;
        end
    end

endmodule

// ==== logic/ring_dispatch.sv ====
`timescale 1ns/1ps

module ring_dispatch
    import ring_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      valid_in,
    input  fu_code_e  unit_in,
    input  rob_idx_t  rob_entry_in,
    input  preg_t     rs1_reg_in,
    input  logic      rs1_ready_in,
    input  xlen_t     rs1_value_in,
    input  preg_t     rs2_reg_in,
    input  logic      rs2_ready_in,
    input  xlen_t     rs2_value_in,
    input  preg_t     dest_reg_in,
    input  uop_code_t uop_code_in,

    output rob_idx_t  logical_rob_entry,
    output preg_t     logical_rs1_reg,
    output logic      logical_rs1_ready,
    output xlen_t     logical_rs1_value,
    output preg_t     logical_rs2_reg,
    output logic      logical_rs2_ready,
    output xlen_t     logical_rs2_value,
    output preg_t     logical_dest_reg,
    output uop_code_t logical_uop_code,
    output logic      logical_valid,

    output rob_idx_t  arithmetic_rob_entry,
    output preg_t     arithmetic_rs1_reg,
    output logic      arithmetic_rs1_ready,
    output xlen_t     arithmetic_rs1_value,
    output preg_t     arithmetic_rs2_reg,
    output logic      arithmetic_rs2_ready,
    output xlen_t     arithmetic_rs2_value,
    output preg_t     arithmetic_dest_reg,
    output uop_code_t arithmetic_uop_code,
    output logic      arithmetic_valid,

    output rob_idx_t  branch_rob_entry,
    output preg_t     branch_rs1_reg,
    output logic      branch_rs1_ready,
    output xlen_t     branch_rs1_value,
    output preg_t     branch_rs2_reg,
    output logic      branch_rs2_ready,
    output xlen_t     branch_rs2_value,
    output preg_t     branch_dest_reg,
    output uop_code_t branch_uop_code,
    output logic      branch_valid,

    output rob_idx_t  mul_div_rob_entry,
    output preg_t     mul_div_rs1_reg,
    output logic      mul_div_rs1_ready,
    output xlen_t     mul_div_rs1_value,
    output preg_t     mul_div_rs2_reg,
    output logic      mul_div_rs2_ready,
    output xlen_t     mul_div_rs2_value,
    output preg_t     mul_div_dest_reg,
    output uop_code_t mul_div_uop_code,
    output logic      mul_div_valid,

    output rob_idx_t  ld_st_rob_entry,
    output preg_t     ld_st_rs1_reg,
    output logic      ld_st_rs1_ready,
    output xlen_t     ld_st_rs1_value,
    output preg_t     ld_st_rs2_reg,
    output logic      ld_st_rs2_ready,
    output xlen_t     ld_st_rs2_value,
    output preg_t     ld_st_dest_reg,
    output uop_code_t ld_st_uop_code,
    output logic      ld_st_valid
);

    uop_if arith_if ();
    uop_if logic_if ();
    uop_if branch_if ();
    uop_if mul_div_if ();
    uop_if ld_st_if ();

    ring_shift ring (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (valid_in),
        .unit_in      (unit_in),
        .rob_entry_in (rob_entry_in),
        .rs1_reg_in   (rs1_reg_in),
        .rs1_ready_in (rs1_ready_in),
        .rs1_value_in (rs1_value_in),
        .rs2_reg_in   (rs2_reg_in),
        .rs2_ready_in (rs2_ready_in),
        .rs2_value_in (rs2_value_in),
        .dest_reg_in  (dest_reg_in),
        .uop_code_in  (uop_code_in),
        .arith_slot   (arith_if.ring),
        .logic_slot   (logic_if.ring),
        .branch_slot  (branch_if.ring),
        .mul_div_slot (mul_div_if.ring),
        .ld_st_slot   (ld_st_if.ring)
    );

    // arithmetic issues two edges after entry.
    issue_port #(.port_unit(fu_arithmetic)) arith_port (
        .clk       (clk),
        .reset     (reset),
        .slot      (arith_if.port),
        .rob_entry (arithmetic_rob_entry),
        .rs1_reg   (arithmetic_rs1_reg),
        .rs1_ready (arithmetic_rs1_ready),
        .rs1_value (arithmetic_rs1_value),
        .rs2_reg   (arithmetic_rs2_reg),
        .rs2_ready (arithmetic_rs2_ready),
        .rs2_value (arithmetic_rs2_value),
        .dest_reg  (arithmetic_dest_reg),
        .uop_code  (arithmetic_uop_code),
        .valid     (arithmetic_valid)
    );

    issue_port #(.port_unit(fu_logical)) logic_port (
        .clk       (clk),
        .reset     (reset),
        .slot      (logic_if.port),
        .rob_entry (logical_rob_entry),
        .rs1_reg   (logical_rs1_reg),
        .rs1_ready (logical_rs1_ready),
        .rs1_value (logical_rs1_value),
        .rs2_reg   (logical_rs2_reg),
        .rs2_ready (logical_rs2_ready),
        .rs2_value (logical_rs2_value),
        .dest_reg  (logical_dest_reg),
        .uop_code  (logical_uop_code),
        .valid     (logical_valid)
    );

    issue_port #(.port_unit(fu_branch)) branch_port (
        .clk       (clk),
        .reset     (reset),
        .slot      (branch_if.port),
        .rob_entry (branch_rob_entry),
        .rs1_reg   (branch_rs1_reg),
        .rs1_ready (branch_rs1_ready),
        .rs1_value (branch_rs1_value),
        .rs2_reg   (branch_rs2_reg),
        .rs2_ready (branch_rs2_ready),
        .rs2_value (branch_rs2_value),
        .dest_reg  (branch_dest_reg),
        .uop_code  (branch_uop_code),
        .valid     (branch_valid)
    );

    issue_port #(.port_unit(fu_mul_div)) mul_div_port (
        .clk       (clk),
        .reset     (reset),
        .slot      (mul_div_if.port),
        .rob_entry (mul_div_rob_entry),
        .rs1_reg   (mul_div_rs1_reg),
        .rs1_ready (mul_div_rs1_ready),
        .rs1_value (mul_div_rs1_value),
        .rs2_reg   (mul_div_rs2_reg),
        .rs2_ready (mul_div_rs2_ready),
        .rs2_value (mul_div_rs2_value),
        .dest_reg  (mul_div_dest_reg),
        .uop_code  (mul_div_uop_code),
        .valid     (mul_div_valid)
    );

    // load/store sits at the tail, six edges after entry.
    issue_port #(.port_unit(fu_ld_st)) ld_st_port (
        .clk       (clk),
        .reset     (reset),
        .slot      (ld_st_if.port),
        .rob_entry (ld_st_rob_entry),
        .rs1_reg   (ld_st_rs1_reg),
        .rs1_ready (ld_st_rs1_ready),
        .rs1_value (ld_st_rs1_value),
        .rs2_reg   (ld_st_rs2_reg),
        .rs2_ready (ld_st_rs2_ready),
        .rs2_value (ld_st_rs2_value),
        .dest_reg  (ld_st_dest_reg),
        .uop_code  (ld_st_uop_code),
        .valid     (ld_st_valid)
    );

endmodule

// ==== tb/ring_dispatch_tb.sv ====
`timescale 1ns/1ps

module ring_dispatch_tb
    import ring_pkg::*;
();

    typedef struct packed {
        rob_idx_t  rob_entry;
        preg_t     rs1_reg;
        logic      rs1_ready;
        xlen_t     rs1_value;
        preg_t     rs2_reg;
        logic      rs2_ready;
        xlen_t     rs2_value;
        preg_t     dest_reg;
        uop_code_t uop_code;
    } payload_t;

    typedef struct {
        int       unit;
        int       due;
        payload_t data;
    } expect_t;

    typedef struct {
        bit valid;
        int unit;
        int gap;
        bit rst;
    } step_t;

    localparam int n_steps = 26;
    localparam int mid_reset_cycles = 4;

    // columns are valid, unit code, idle cycles after and reset after.
    step_t steps [n_steps] = '{
        '{1, 2, 8, 0}, '{1, 1, 8, 0}, '{1, 3, 8, 0}, '{1, 4, 8, 0}, '{1, 5, 8, 0},
        '{1, 0, 8, 0}, '{1, 6, 8, 0}, '{1, 7, 8, 0}, '{0, 2, 8, 0},
        '{1, 5, 0, 0}, '{1, 4, 0, 0}, '{1, 3, 0, 0}, '{1, 1, 0, 0}, '{1, 2, 0, 0},
        '{1, 2, 0, 0}, '{1, 6, 0, 0}, '{1, 5, 0, 0}, '{1, 1, 8, 0},
        // these three fill the head and two slots when reset hits.
        '{1, 5, 0, 0}, '{1, 2, 0, 0}, '{1, 5, 0, 1},
        '{1, 2, 8, 0}, '{1, 1, 8, 0}, '{1, 3, 8, 0}, '{1, 4, 8, 0}, '{1, 5, 8, 0}
    };

    logic      clk = 1'b0;
    logic      reset;
    logic      valid_in;
    fu_code_e  unit_in;
    rob_idx_t  rob_entry_in;
    preg_t     rs1_reg_in;
    logic      rs1_ready_in;
    xlen_t     rs1_value_in;
    preg_t     rs2_reg_in;
    logic      rs2_ready_in;
    xlen_t     rs2_value_in;
    preg_t     dest_reg_in;
    uop_code_t uop_code_in;

    rob_idx_t  logical_rob_entry, arithmetic_rob_entry, branch_rob_entry,
               mul_div_rob_entry, ld_st_rob_entry;
    preg_t     logical_rs1_reg, arithmetic_rs1_reg, branch_rs1_reg,
               mul_div_rs1_reg, ld_st_rs1_reg;
    logic      logical_rs1_ready, arithmetic_rs1_ready, branch_rs1_ready,
               mul_div_rs1_ready, ld_st_rs1_ready;
    xlen_t     logical_rs1_value, arithmetic_rs1_value, branch_rs1_value,
               mul_div_rs1_value, ld_st_rs1_value;
    preg_t     logical_rs2_reg, arithmetic_rs2_reg, branch_rs2_reg,
               mul_div_rs2_reg, ld_st_rs2_reg;
    logic      logical_rs2_ready, arithmetic_rs2_ready, branch_rs2_ready,
               mul_div_rs2_ready, ld_st_rs2_ready;
    xlen_t     logical_rs2_value, arithmetic_rs2_value, branch_rs2_value,
               mul_div_rs2_value, ld_st_rs2_value;
    preg_t     logical_dest_reg, arithmetic_dest_reg, branch_dest_reg,
               mul_div_dest_reg, ld_st_dest_reg;
    uop_code_t logical_uop_code, arithmetic_uop_code, branch_uop_code,
               mul_div_uop_code, ld_st_uop_code;
    logic      logical_valid, arithmetic_valid, branch_valid,
               mul_div_valid, ld_st_valid;

    expect_t pending [$];
    int      cycle = 0;
    int      limit = 0;
    int      field_errors = 0;
    int      pulse_errors = 0;
    integer  seed = 81716;

    ring_dispatch uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("run timed out at cycle %0d with %0d items pending", cycle, pending.size());
            $display("=== FAIL ===");
            $finish;
        end
    end

    // edges from entry to the valid pulse for each unit code.
    function automatic int port_latency(input int unit);
        case (unit)
            2: return 2; // arithmetic slot comes first in the ring.
            1: return 3;
            3: return 4;
            4: return 5;
            default: return 6;
        endcase
    endfunction

    function automatic string port_name(input int unit);
        case (unit)
            1: return "logical";
            2: return "arithmetic";
            3: return "branch";
            4: return "mul_div";
            default: return "ld_st";
        endcase
    endfunction

    function automatic logic actual_valid(input int unit);
        case (unit)
            1: return logical_valid;
            2: return arithmetic_valid;
            3: return branch_valid;
            4: return mul_div_valid;
            default: return ld_st_valid;
        endcase
    endfunction

    function automatic payload_t actual_payload(input int unit);
        case (unit)
            1: return {logical_rob_entry, logical_rs1_reg, logical_rs1_ready, logical_rs1_value,
                       logical_rs2_reg, logical_rs2_ready, logical_rs2_value,
                       logical_dest_reg, logical_uop_code};
            2: return {arithmetic_rob_entry, arithmetic_rs1_reg, arithmetic_rs1_ready,
                       arithmetic_rs1_value, arithmetic_rs2_reg, arithmetic_rs2_ready,
                       arithmetic_rs2_value, arithmetic_dest_reg, arithmetic_uop_code};
            3: return {branch_rob_entry, branch_rs1_reg, branch_rs1_ready, branch_rs1_value,
                       branch_rs2_reg, branch_rs2_ready, branch_rs2_value,
                       branch_dest_reg, branch_uop_code};
            4: return {mul_div_rob_entry, mul_div_rs1_reg, mul_div_rs1_ready, mul_div_rs1_value,
                       mul_div_rs2_reg, mul_div_rs2_ready, mul_div_rs2_value,
                       mul_div_dest_reg, mul_div_uop_code};
            default: return {ld_st_rob_entry, ld_st_rs1_reg, ld_st_rs1_ready, ld_st_rs1_value,
                             ld_st_rs2_reg, ld_st_rs2_ready, ld_st_rs2_value,
                             ld_st_dest_reg, ld_st_uop_code};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            field_errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_port(input int unit);
        int       idx;
        logic     act_valid;
        payload_t act;
        payload_t exp;
        string    name;
        idx = -1;
        act_valid = actual_valid(unit);
        act = actual_payload(unit);
        name = port_name(unit);
        for (int i = 0; i < pending.size(); i++) begin
            if (pending[i].unit == unit && pending[i].due == cycle) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            assert (act_valid === 1'b0) else begin
                pulse_errors++;
                $display("%0t: %s_valid pulsed on cycle %0d with no item due", $time, name, cycle);
            end
        end else begin
            exp = pending[idx].data;
            assert (act_valid === 1'b1) else begin
                pulse_errors++;
                $display("%0t: %s_valid stayed low on cycle %0d with an item due",
                         $time, name, cycle);
            end
            if (act_valid === 1'b1) begin
                check_value({name, "_rob_entry"}, exp.rob_entry, act.rob_entry);
                check_value({name, "_rs1_reg"}, exp.rs1_reg, act.rs1_reg);
                check_value({name, "_rs1_ready"}, exp.rs1_ready, act.rs1_ready);
                check_value({name, "_rs1_value"}, exp.rs1_value, act.rs1_value);
                check_value({name, "_rs2_reg"}, exp.rs2_reg, act.rs2_reg);
                check_value({name, "_rs2_ready"}, exp.rs2_ready, act.rs2_ready);
                check_value({name, "_rs2_value"}, exp.rs2_value, act.rs2_value);
                check_value({name, "_dest_reg"}, exp.dest_reg, act.dest_reg);
                check_value({name, "_uop_code"}, exp.uop_code, act.uop_code);
            end
            pending.delete(idx);
        end
    endtask

    // all five ports are checked on each falling edge.
    always @(negedge clk) begin
        for (int u = 1; u <= 5; u++) begin
            check_port(u);
        end
    end

    task automatic check_idle();
        @(negedge clk);
        assert ({logical_valid, arithmetic_valid, branch_valid,
                 mul_div_valid, ld_st_valid} === 5'b0) else begin
            pulse_errors++;
            $display("%0t: a valid output is not low right after reset", $time);
        end
    endtask

    task automatic send_step(input step_t s);
        expect_t e;
        e.data.rob_entry = $random(seed);
        e.data.rs1_reg   = $random(seed);
        e.data.rs1_ready = $random(seed);
        e.data.rs1_value = $random(seed);
        e.data.rs2_reg   = $random(seed);
        e.data.rs2_ready = $random(seed);
        e.data.rs2_value = $random(seed);
        e.data.dest_reg  = $random(seed);
        e.data.uop_code  = $random(seed);
        @(posedge clk);
        valid_in     <= s.valid;
        unit_in      <= fu_code_e'(s.unit[2:0]);
        rob_entry_in <= e.data.rob_entry;
        rs1_reg_in   <= e.data.rs1_reg;
        rs1_ready_in <= e.data.rs1_ready;
        rs1_value_in <= e.data.rs1_value;
        rs2_reg_in   <= e.data.rs2_reg;
        rs2_ready_in <= e.data.rs2_ready;
        rs2_value_in <= e.data.rs2_value;
        dest_reg_in  <= e.data.dest_reg;
        uop_code_in  <= e.data.uop_code;
        if (s.valid && s.unit >= 1 && s.unit <= 5) begin
            e.unit = s.unit;
            e.due  = cycle + 2 + port_latency(s.unit); // taken at the next edge.
            pending.push_back(e);
        end
        repeat (s.gap) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        reset    <= 1'b1;
        valid_in <= 1'b0;
        // whatever has not issued by the next edge is lost.
        for (int i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].due > cycle + 1) begin
                pending.delete(i);
            end
        end
        repeat (cycles) @(posedge clk);
        reset <= 1'b0;
        check_idle();
    endtask

    initial begin
        int gap_total;
        int reset_total;
        reset        = 1'b1;
        valid_in     = 1'b0;
        unit_in      = fu_none;
        rob_entry_in = '0;
        rs1_reg_in   = '0;
        rs1_ready_in = 1'b0;
        rs1_value_in = '0;
        rs2_reg_in   = '0;
        rs2_ready_in = 1'b0;
        rs2_value_in = '0;
        dest_reg_in  = '0;
        uop_code_in  = '0;
        gap_total = 0;
        reset_total = 0;
        foreach (steps[i]) begin
            gap_total += steps[i].gap;
            if (steps[i].rst) begin
                reset_total += mid_reset_cycles + 1;
            end
        end
        limit = 16 + n_steps + gap_total + reset_total + 6 + 20;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_idle();

        foreach (steps[i]) begin
            send_step(steps[i]);
            if (steps[i].rst) begin
                apply_reset(mid_reset_cycles);
            end
        end

        while (pending.size() > 0) @(posedge clk);
        repeat (8) @(posedge clk); // catch stray pulses.
        $display("errors: %0d field mismatches, %0d pulse errors", field_errors, pulse_errors);
        if (field_errors + pulse_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/ring_pkg.sv
logic/uop_if.sv
logic/ring_shift.sv
logic/issue_port.sv
logic/ring_dispatch.sv
tb/ring_dispatch_tb.sv

// ==== Bender.yml ====
package:
  name: ring_dispatch

export_include_dirs:
  - include

sources:
  - files:
      - logic/ring_pkg.sv
      - logic/uop_if.sv
      - logic/ring_shift.sv
      - logic/issue_port.sv
      - logic/ring_dispatch.sv
  - target: test
    files:
      - tb/ring_dispatch_tb.sv
